/* Makefile */
# Verilator build and run of the AXI write upsizer testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_upsize
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)
	@echo "Simulation OK"

clean:
	rm -rf $(BUILD) $(LOG)

/* compile.f */
+incdir+design
+incdir+sim
design/upsize_pkg.sv
design/aw_upsizer.sv
design/w_packer.sv
design/wide_w_fifo.sv
design/wide_mem_sink.sv
design/axi_write_upsize.sv
sim/tb_upsize.sv

/* design/aw_upsizer.sv */
module aw_upsizer (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Narrow AW
  input  logic               aw_valid,
  input  upsize_pkg::addr_t  aw_addr,
  input  upsize_pkg::len_t   aw_len,
  input  upsize_pkg::size_t  aw_size,
  input  upsize_pkg::burst_t aw_burst,
  input  logic               aw_modifiable,
  output logic               aw_ready,
  // Burst command to the packer
  output logic               cmd_valid,
  output upsize_pkg::addr_t  cmd_addr,
  output upsize_pkg::size_t  cmd_size,
  output upsize_pkg::len_t   cmd_len,
  output logic               cmd_pack,
  input  logic               cmd_ready,
  // Wide AW to the sink
  output logic               waw_valid,
  output upsize_pkg::addr_t  waw_addr,
  output upsize_pkg::len_t   waw_len,
  input  logic               waw_ready
);

  localparam int unsigned WIDE_OFF_W = $clog2($bits(upsize_pkg::wide_strb_t));
  localparam upsize_pkg::addr_t WIDE_MASK = upsize_pkg::addr_t'((1 << WIDE_OFF_W) - 1);

  logic              pack_d;
  logic              aw_fire;
  upsize_pkg::addr_t size_mask;
  upsize_pkg::addr_t start_aligned;
  upsize_pkg::addr_t end_aligned;
  upsize_pkg::len_t  wide_len;

  // Idle only once both the command and the wide AW are gone
  assign aw_ready = aw_valid && !cmd_valid && !waw_valid;
  assign aw_fire  = aw_valid && aw_ready;

  // ------------------------------
  // Mode and wide length
  // ------------------------------

  always_comb begin
    pack_d        = aw_modifiable && (aw_burst == upsize_pkg::INCR);
    size_mask     = upsize_pkg::addr_t'((1 << aw_size) - 1);
    start_aligned = aw_addr & ~WIDE_MASK;
    end_aligned   = ((aw_addr & ~size_mask) + (upsize_pkg::addr_t'(aw_len) << aw_size))
                    & ~WIDE_MASK;
    // Pass-through keeps the narrow beat count
    if (pack_d) begin
      wide_len = upsize_pkg::len_t'((end_aligned - start_aligned) >> WIDE_OFF_W);
    end else begin
      wide_len = aw_len;
    end
  end

  // ------------------------------
  // Handshake state
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid <= 1'b0;
      waw_valid <= 1'b0;
    end else if (aw_fire) begin
      cmd_valid <= 1'b1;
      waw_valid <= 1'b1;
    end else begin
      if (cmd_ready) begin
        cmd_valid <= 1'b0;
      end
      if (waw_ready) begin
        waw_valid <= 1'b0;
      end
    end
  end

  // Request fields, held until both sides have taken them
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      cmd_addr <= aw_addr;
      cmd_size <= aw_size;
      cmd_len  <= aw_len;
      cmd_pack <= pack_d;
      waw_addr <= start_aligned;
      waw_len  <= wide_len;
    end
  end

endmodule

/* design/axi_write_upsize.sv */
module axi_write_upsize (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Narrow AW
  input  logic                     aw_valid,
  input  upsize_pkg::addr_t        aw_addr,
  input  upsize_pkg::len_t         aw_len,
  input  upsize_pkg::size_t        aw_size,
  input  upsize_pkg::burst_t       aw_burst,
  input  logic                     aw_modifiable,
  output logic                     aw_ready,
  // Narrow W
  input  logic                     w_valid,
  input  upsize_pkg::narrow_data_t w_data,
  input  upsize_pkg::narrow_strb_t w_strb,
  input  logic                     w_last,
  output logic                     w_ready,
  // B
  output logic                     b_valid,
  output upsize_pkg::resp_t        b_resp,
  input  logic                     b_ready,
  // Scratchpad readback
  input  upsize_pkg::addr_t        rd_addr,
  output upsize_pkg::wide_data_t   rd_data
);

  // Producer to packer
  logic              cmd_valid;
  logic              cmd_ready;
  upsize_pkg::addr_t cmd_addr;
  upsize_pkg::size_t cmd_size;
  upsize_pkg::len_t  cmd_len;
  logic              cmd_pack;

  // Producer to sink
  logic              waw_valid;
  logic              waw_ready;
  upsize_pkg::addr_t waw_addr;
  upsize_pkg::len_t  waw_len;

  // Packer to FIFO
  logic                   pk_wb_valid;
  logic                   pk_wb_ready;
  upsize_pkg::wide_data_t pk_wb_data;
  upsize_pkg::wide_strb_t pk_wb_strb;
  logic                   pk_wb_last;

  // FIFO to sink
  logic                   wb_valid;
  logic                   wb_ready;
  upsize_pkg::wide_data_t wb_data;
  upsize_pkg::wide_strb_t wb_strb;
  logic                   wb_last;

  aw_upsizer u_aw_upsizer (
    .clk_i, .rst_ni,
    .aw_valid, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_modifiable, .aw_ready,
    .cmd_valid, .cmd_addr, .cmd_size, .cmd_len, .cmd_pack, .cmd_ready,
    .waw_valid, .waw_addr, .waw_len, .waw_ready
  );

  w_packer u_w_packer (
    .clk_i, .rst_ni,
    .cmd_valid, .cmd_addr, .cmd_size, .cmd_len, .cmd_pack, .cmd_ready,
    .w_valid, .w_data, .w_strb, .w_last, .w_ready,
    .wb_valid (pk_wb_valid),
    .wb_data  (pk_wb_data),
    .wb_strb  (pk_wb_strb),
    .wb_last  (pk_wb_last),
    .wb_ready (pk_wb_ready)
  );

  wide_w_fifo u_wide_w_fifo (
    .clk_i, .rst_ni,
    .in_valid  (pk_wb_valid),
    .in_data   (pk_wb_data),
    .in_strb   (pk_wb_strb),
    .in_last   (pk_wb_last),
    .in_ready  (pk_wb_ready),
    .out_valid (wb_valid),
    .out_data  (wb_data),
    .out_strb  (wb_strb),
    .out_last  (wb_last),
    .out_ready (wb_ready)
  );

  wide_mem_sink u_wide_mem_sink (
    .clk_i, .rst_ni,
    .waw_valid, .waw_addr, .waw_len, .waw_ready,
    .wb_valid, .wb_data, .wb_strb, .wb_last, .wb_ready,
    .b_valid, .b_resp, .b_ready,
    .rd_addr, .rd_data
  );

endmodule

/* design/upsize_pkg.sv */
`include "upsize_settings.svh"

package upsize_pkg;

  // ------------------------------
  // Address and burst fields
  // ------------------------------

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`LEN_W-1:0]  len_t;
  typedef logic [2:0]         size_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  // ------------------------------
  // Data and strobes
  // ------------------------------

  typedef logic [`NARROW_DATA_W-1:0]   narrow_data_t;
  typedef logic [`NARROW_DATA_W/8-1:0] narrow_strb_t;

  typedef logic [`WIDE_DATA_W-1:0]     wide_data_t;
  typedef logic [`WIDE_DATA_W/8-1:0]   wide_strb_t;

endpackage

/* design/upsize_settings.svh */
`ifndef UPSIZE_SETTINGS_SVH
`define UPSIZE_SETTINGS_SVH

// Narrow master side
`define NARROW_DATA_W 32

// Wide scratchpad side
`define WIDE_DATA_W 128

// Address and burst length widths
`define ADDR_W 16
`define LEN_W 8

// Wide beat FIFO entries, power of two
`define WFIFO_DEPTH 4

// Scratchpad size in wide words
`define MEM_WORDS 64

`endif

/* design/w_packer.sv */
module w_packer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Burst command
  input  logic                     cmd_valid,
  input  upsize_pkg::addr_t        cmd_addr,
  input  upsize_pkg::size_t        cmd_size,
  input  upsize_pkg::len_t         cmd_len,
  input  logic                     cmd_pack,
  output logic                     cmd_ready,
  // Narrow W
  input  logic                     w_valid,
  input  upsize_pkg::narrow_data_t w_data,
  input  upsize_pkg::narrow_strb_t w_strb,
  input  logic                     w_last,
  output logic                     w_ready,
  // Wide beats
  output logic                     wb_valid,
  output upsize_pkg::wide_data_t   wb_data,
  output upsize_pkg::wide_strb_t   wb_strb,
  output logic                     wb_last,
  input  logic                     wb_ready
);

  localparam int unsigned NB      = $bits(upsize_pkg::narrow_strb_t);
  localparam int unsigned WB      = $bits(upsize_pkg::wide_strb_t);
  localparam int unsigned N_OFF_W = $clog2(NB);
  localparam int unsigned W_OFF_W = $clog2(WB);
  localparam upsize_pkg::addr_t WIDE_MASK = upsize_pkg::addr_t'((1 << W_OFF_W) - 1);

  logic                   busy_q;
  logic                   pack_q;
  upsize_pkg::addr_t      addr_q;
  upsize_pkg::size_t      size_q;
  upsize_pkg::len_t       rem_q;
  upsize_pkg::wide_data_t acc_data_q;
  upsize_pkg::wide_strb_t acc_strb_q;

  logic                           cmd_fire;
  logic                           beat_fire;
  logic                           burst_end;
  logic                           emit;
  upsize_pkg::addr_t              size_mask;
  upsize_pkg::addr_t              beat_aligned;
  upsize_pkg::addr_t              next_addr;
  logic [N_OFF_W:0]               lane_end;
  logic [W_OFF_W-N_OFF_W-1:0]     word_sel;
  upsize_pkg::wide_data_t         merged_data;
  upsize_pkg::wide_strb_t         merged_strb;

  assign cmd_ready = cmd_valid && !busy_q;
  assign cmd_fire  = cmd_valid && cmd_ready;
  // Take a beat only if the output register is free or draining
  assign w_ready   = busy_q && (!wb_valid || wb_ready);
  assign beat_fire = w_valid && w_ready;
  assign burst_end = (rem_q == '0) || w_last;

  // ------------------------------
  // Lane steering
  // ------------------------------

  always_comb begin
    size_mask    = upsize_pkg::addr_t'((1 << size_q) - 1);
    beat_aligned = addr_q & ~size_mask;
    next_addr    = beat_aligned + upsize_pkg::addr_t'(1 << size_q);
    lane_end     = {1'b0, beat_aligned[N_OFF_W-1:0]} + (N_OFF_W+1)'(1 << size_q);
    word_sel     = addr_q[W_OFF_W-1:N_OFF_W];
    merged_data  = acc_data_q;
    merged_strb  = acc_strb_q;
    for (int b = 0; b < NB; b++) begin
      // Bytes below the address offset are not part of this beat
      if ((b >= addr_q[N_OFF_W-1:0]) && (b < lane_end)) begin
        merged_data[8*(int'(word_sel)*NB + b) +: 8] = w_data[8*b +: 8];
        merged_strb[int'(word_sel)*NB + b]          = w_strb[b];
      end
    end
    // Flush on every beat in pass-through, else at a word boundary or the end
    emit = !pack_q || burst_end || ((next_addr & ~WIDE_MASK) != (addr_q & ~WIDE_MASK));
  end

  // ------------------------------
  // Control
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (cmd_fire) begin
        busy_q <= 1'b1;
      end else if (beat_fire && burst_end) begin
        busy_q <= 1'b0;
      end
      if (beat_fire && emit) begin
        wb_valid <= 1'b1;
      end else if (wb_ready) begin
        wb_valid <= 1'b0;
      end
    end
  end

  // Burst state and data path
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      addr_q     <= cmd_addr;
      size_q     <= cmd_size;
      rem_q      <= cmd_len;
      pack_q     <= cmd_pack;
      acc_data_q <= '0;
      acc_strb_q <= '0;
    end else if (beat_fire) begin
      addr_q <= next_addr;
      rem_q  <= rem_q - 1'b1;
      if (emit) begin
        wb_data    <= merged_data;
        wb_strb    <= merged_strb;
        wb_last    <= burst_end;
        acc_data_q <= '0;
        acc_strb_q <= '0;
      end else begin
        acc_data_q <= merged_data;
        acc_strb_q <= merged_strb;
      end
    end
  end

endmodule

/* design/wide_mem_sink.sv */
`include "upsize_settings.svh"

module wide_mem_sink (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Wide AW
  input  logic                   waw_valid,
  input  upsize_pkg::addr_t      waw_addr,
  input  upsize_pkg::len_t       waw_len,
  output logic                   waw_ready,
  // Wide W
  input  logic                   wb_valid,
  input  upsize_pkg::wide_data_t wb_data,
  input  upsize_pkg::wide_strb_t wb_strb,
  input  logic                   wb_last,
  output logic                   wb_ready,
  // B
  output logic                   b_valid,
  output upsize_pkg::resp_t      b_resp,
  input  logic                   b_ready,
  // Readback
  input  upsize_pkg::addr_t      rd_addr,
  output upsize_pkg::wide_data_t rd_data
);

  localparam int unsigned WB        = $bits(upsize_pkg::wide_strb_t);
  localparam int unsigned OFF_W     = $clog2(WB);
  localparam int unsigned IDX_W     = `ADDR_W - OFF_W;
  localparam int unsigned MEM_IDX_W = $clog2(`MEM_WORDS);

  upsize_pkg::wide_data_t mem_q [`MEM_WORDS];

  logic             active_q;
  logic             err_q;
  logic [IDX_W-1:0] word_q;
  upsize_pkg::len_t len_q;
  upsize_pkg::len_t cnt_q;
  logic             waw_fire;
  logic             beat_fire;
  logic             in_range;
  logic [IDX_W-1:0] rd_idx;

  assign waw_ready = waw_valid && !active_q && !b_valid;
  assign waw_fire  = waw_valid && waw_ready;
  assign wb_ready  = active_q;
  assign beat_fire = wb_valid && wb_ready;
  assign in_range  = word_q < IDX_W'(`MEM_WORDS);

  // ------------------------------
  // Burst tracking and response
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      err_q    <= 1'b0;
      cnt_q    <= '0;
      b_valid  <= 1'b0;
      b_resp   <= upsize_pkg::OKAY;
    end else begin
      if (waw_fire) begin
        active_q <= 1'b1;
        err_q    <= 1'b0;
        cnt_q    <= '0;
      end else if (beat_fire) begin
        cnt_q <= cnt_q + 1'b1;
        // Out of range beats are dropped but remembered
        if (!in_range) begin
          err_q <= 1'b1;
        end
        if (wb_last) begin
          active_q <= 1'b0;
          b_valid  <= 1'b1;
          b_resp   <= (err_q || !in_range || (cnt_q != len_q)) ?
                      upsize_pkg::SLVERR : upsize_pkg::OKAY;
        end
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // One wide word per beat, also for FIXED
  always_ff @(posedge clk_i) begin
    if (waw_fire) begin
      word_q <= waw_addr[`ADDR_W-1:OFF_W];
      len_q  <= waw_len;
    end else if (beat_fire) begin
      word_q <= word_q + 1'b1;
    end
  end

  // ------------------------------
  // Scratchpad
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (beat_fire && in_range) begin
      for (int b = 0; b < WB; b++) begin
        if (wb_strb[b]) begin
          mem_q[word_q[MEM_IDX_W-1:0]][8*b +: 8] <= wb_data[8*b +: 8];
        end
      end
    end
  end

  assign rd_idx  = rd_addr[`ADDR_W-1:OFF_W];
  assign rd_data = (rd_idx < IDX_W'(`MEM_WORDS)) ? mem_q[rd_idx[MEM_IDX_W-1:0]] : '0;

endmodule

/* design/wide_w_fifo.sv */
`include "upsize_settings.svh"

module wide_w_fifo #(
  parameter int unsigned DEPTH = `WFIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid,
  input  upsize_pkg::wide_data_t in_data,
  input  upsize_pkg::wide_strb_t in_strb,
  input  logic                   in_last,
  output logic                   in_ready,
  output logic                   out_valid,
  output upsize_pkg::wide_data_t out_data,
  output upsize_pkg::wide_strb_t out_strb,
  output logic                   out_last,
  input  logic                   out_ready
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  upsize_pkg::wide_data_t data_mem [DEPTH];
  upsize_pkg::wide_strb_t strb_mem [DEPTH];
  logic                   last_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  assign in_ready  = count_q != (PTR_W+1)'(DEPTH);
  assign out_valid = count_q != '0;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  assign out_data = data_mem[rd_ptr_q];
  assign out_strb = strb_mem[rd_ptr_q];
  assign out_last = last_mem[rd_ptr_q];

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q] <= in_data;
      strb_mem[wr_ptr_q] <= in_strb;
      last_mem[wr_ptr_q] <= in_last;
    end
  end

endmodule

/* sim/tb_upsize_tasks.svh */
`ifndef TB_UPSIZE_TASKS_SVH
`define TB_UPSIZE_TASKS_SVH

// ------------------------------
// Stimulus and reference model
// ------------------------------

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic upsize_pkg::wide_data_t model_word(int unsigned idx);
  upsize_pkg::wide_data_t word;
  for (int b = 0; b < WIDE_BYTES; b++) begin
    word[8*b +: 8] = model_mem[idx*WIDE_BYTES + b];
  end
  return word;
endfunction

task automatic note_timeout(string what);
  $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
  timeout_count++;
endtask

task automatic compare_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    mismatch_count++;
  end
endtask

task automatic compare_resp(string name, upsize_pkg::resp_t got, upsize_pkg::resp_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    mismatch_count++;
  end
endtask

task automatic compare_word(string name, upsize_pkg::wide_data_t got,
                            upsize_pkg::wide_data_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    mismatch_count++;
  end
endtask

// ------------------------------
// Bus drivers
// ------------------------------

task automatic drive_aw(upsize_pkg::addr_t addr, upsize_pkg::len_t len,
                        upsize_pkg::size_t size, upsize_pkg::burst_t burst,
                        logic modifiable);
  int unsigned cycles;
  bit          done;
  @(negedge clk_i);
  aw_addr       = addr;
  aw_len        = len;
  aw_size       = size;
  aw_burst      = burst;
  aw_modifiable = modifiable;
  aw_valid      = 1'b1;
  cycles = 0;
  done   = 1'b0;
  while (!done && cycles < WAIT_LIMIT) begin
    @(posedge clk_i);
    done = aw_ready;
    cycles++;
  end
  if (!done) note_timeout("AW handshake");
  @(negedge clk_i);
  aw_valid = 1'b0;
endtask

// Drives one burst and applies each beat to the model
task automatic drive_w_burst(upsize_pkg::addr_t addr, upsize_pkg::len_t len,
                             upsize_pkg::size_t size, logic pack, logic partial);
  int unsigned              a;
  int unsigned              step;
  int unsigned              lo;
  int unsigned              hi;
  int unsigned              byte_addr;
  int unsigned              cycles;
  bit                       done;
  upsize_pkg::narrow_strb_t active;
  a    = addr;
  step = 1 << size;
  for (int k = 0; k <= int'(len); k++) begin
    // Active lanes run from the address to the end of its size container
    lo     = a % NARROW_BYTES;
    hi     = (a & ~(step - 1)) % NARROW_BYTES + step;
    active = '0;
    for (int b = lo; b < hi; b++) begin
      active[b] = 1'b1;
    end
    @(negedge clk_i);
    w_data  = lcg_next();
    w_strb  = partial ? (upsize_pkg::narrow_strb_t'(lcg_next() >> 16) & active) : active;
    w_last  = (k == int'(len));
    w_valid = 1'b1;
    for (int b = 0; b < NARROW_BYTES; b++) begin
      // Pass-through puts beat k into wide word start+k
      if (pack) begin
        byte_addr = (a & ~(NARROW_BYTES - 1)) + b;
      end else begin
        byte_addr = ((addr / WIDE_BYTES) + k) * WIDE_BYTES
                    + ((a % WIDE_BYTES) & ~(NARROW_BYTES - 1)) + b;
      end
      if (w_strb[b] && byte_addr < MEM_BYTES) begin
        model_mem[byte_addr] = w_data[8*b +: 8];
      end
    end
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      done = w_ready;
      cycles++;
    end
    if (!done) note_timeout("W beat handshake");
    a = (a & ~(step - 1)) + step;
  end
  @(negedge clk_i);
  w_valid = 1'b0;
  w_last  = 1'b0;
endtask

task automatic wait_b(upsize_pkg::resp_t exp);
  int unsigned cycles;
  bit          done;
  @(negedge clk_i);
  b_ready = 1'b1;
  cycles  = 0;
  done    = 1'b0;
  while (!done && cycles < WAIT_LIMIT) begin
    @(posedge clk_i);
    done = b_valid;
    if (done) compare_resp("b_resp", b_resp, exp);
    cycles++;
  end
  if (!done) note_timeout("B response");
  @(negedge clk_i);
  b_ready = 1'b0;
endtask

// Needs w_ready low with w_valid high for a run of cycles
task automatic wait_w_stall(int unsigned run);
  int unsigned cycles;
  int unsigned stalled;
  cycles  = 0;
  stalled = 0;
  while (stalled < run && cycles < WAIT_LIMIT) begin
    @(posedge clk_i);
    stalled = (w_valid && !w_ready) ? stalled + 1 : 0;
    cycles++;
  end
  if (stalled < run) note_timeout("w_ready stall under B back-pressure");
endtask

task automatic check_memory();
  for (int i = 0; i < `MEM_WORDS; i++) begin
    @(negedge clk_i);
    rd_addr = upsize_pkg::addr_t'(i * WIDE_BYTES);
    @(posedge clk_i);
    compare_word($sformatf("rd_data[%0d]", i), rd_data, model_word(i));
  end
endtask

// ------------------------------
// Directed tests
// ------------------------------

task automatic check_reset_state();
  repeat (3) begin
    @(posedge clk_i);
    compare_bit("aw_ready", aw_ready, 1'b0);
    compare_bit("w_ready", w_ready, 1'b0);
    compare_bit("b_valid", b_valid, 1'b0);
  end
  check_memory();
endtask

// Ten word beats from 0x48 touch wide words 4 to 6
task automatic pack_unaligned_incr();
  drive_aw(16'h0048, 8'd9, 3'd2, upsize_pkg::INCR, 1'b1);
  drive_w_burst(16'h0048, 8'd9, 3'd2, 1'b1, 1'b0);
  wait_b(upsize_pkg::OKAY);
  check_memory();
endtask

task automatic passthrough_partial_strobes();
  // Background first so unstrobed bytes are visible
  drive_aw(16'h0200, 8'd15, 3'd2, upsize_pkg::INCR, 1'b1);
  drive_w_burst(16'h0200, 8'd15, 3'd2, 1'b1, 1'b0);
  wait_b(upsize_pkg::OKAY);
  drive_aw(16'h0200, 8'd3, 3'd2, upsize_pkg::INCR, 1'b0);
  drive_w_burst(16'h0200, 8'd3, 3'd2, 1'b0, 1'b1);
  wait_b(upsize_pkg::OKAY);
  check_memory();
endtask

task automatic halfword_byte_strobes();
  drive_aw(16'h00A5, 8'd11, 3'd1, upsize_pkg::INCR, 1'b1);
  drive_w_burst(16'h00A5, 8'd11, 3'd1, 1'b1, 1'b1);
  wait_b(upsize_pkg::OKAY);
  check_memory();
endtask

// Words 62 and 63 in range, the rest past the scratchpad
task automatic overrun_slverr();
  drive_aw(16'h03E8, 8'd15, 3'd2, upsize_pkg::INCR, 1'b1);
  drive_w_burst(16'h03E8, 8'd15, 3'd2, 1'b1, 1'b0);
  wait_b(upsize_pkg::SLVERR);
  check_memory();
endtask

task automatic b_backpressure();
  drive_aw(16'h0100, 8'd7, 3'd2, upsize_pkg::INCR, 1'b1);
  drive_w_burst(16'h0100, 8'd7, 3'd2, 1'b1, 1'b0);
  // First B is left pending, second burst backs up behind it
  drive_aw(16'h02C0, 8'd7, 3'd2, upsize_pkg::INCR, 1'b0);
  fork
    drive_w_burst(16'h02C0, 8'd7, 3'd2, 1'b0, 1'b0);
    begin
      wait_w_stall(8);
      wait_b(upsize_pkg::OKAY);
    end
  join
  wait_b(upsize_pkg::OKAY);
  check_memory();
endtask

`endif

/* sim/tb_upsize.sv */
`include "upsize_settings.svh"

module tb_upsize;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned WAIT_LIMIT   = 200;
  localparam int unsigned NARROW_BYTES = `NARROW_DATA_W / 8;
  localparam int unsigned WIDE_BYTES   = `WIDE_DATA_W / 8;
  localparam int unsigned MEM_BYTES    = `MEM_WORDS * WIDE_BYTES;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     aw_valid;
  upsize_pkg::addr_t        aw_addr;
  upsize_pkg::len_t         aw_len;
  upsize_pkg::size_t        aw_size;
  upsize_pkg::burst_t       aw_burst;
  logic                     aw_modifiable;
  logic                     aw_ready;
  logic                     w_valid;
  upsize_pkg::narrow_data_t w_data;
  upsize_pkg::narrow_strb_t w_strb;
  logic                     w_last;
  logic                     w_ready;
  logic                     b_valid;
  upsize_pkg::resp_t        b_resp;
  logic                     b_ready;
  upsize_pkg::addr_t        rd_addr;
  upsize_pkg::wide_data_t   rd_data;

  // Byte image of the scratchpad
  logic [7:0]  model_mem [MEM_BYTES];
  logic [31:0] lcg_state;
  int unsigned mismatch_count;
  int unsigned timeout_count;

  axi_write_upsize u_dut (
    .clk_i, .rst_ni,
    .aw_valid, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_modifiable, .aw_ready,
    .w_valid, .w_data, .w_strb, .w_last, .w_ready,
    .b_valid, .b_resp, .b_ready,
    .rd_addr, .rd_data
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  `include "tb_upsize_tasks.svh"

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    rst_ni        = 1'b0;
    aw_valid      = 1'b0;
    aw_addr       = '0;
    aw_len        = '0;
    aw_size       = '0;
    aw_burst      = upsize_pkg::INCR;
    aw_modifiable = 1'b0;
    w_valid       = 1'b0;
    w_data        = '0;
    w_strb        = '0;
    w_last        = 1'b0;
    b_ready       = 1'b0;
    rd_addr       = '0;
    lcg_state      = 32'd15523;
    mismatch_count = 0;
    timeout_count  = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    check_reset_state();
    // A timeout leaves the DUT mid-burst, so later tests are skipped
    if (timeout_count == 0) pack_unaligned_incr();
    if (timeout_count == 0) passthrough_partial_strobes();
    if (timeout_count == 0) halfword_byte_strobes();
    if (timeout_count == 0) overrun_slverr();
    if (timeout_count == 0) b_backpressure();

    $display("Errors: %0d (mismatches %0d, timeouts %0d)",
             mismatch_count + timeout_count, mismatch_count, timeout_count);
    if ((mismatch_count + timeout_count) == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
